// File: source/cache_pkg.sv
package cache_pkg;

    // word and strobe widths
    localparam int WORD_WIDTH = 32;
    localparam int STRB_WIDTH = 4;

    // line geometry, four words per line
    localparam int WORDS_PER_LINE = 4;
    localparam int WORD_SEL_WIDTH = 2;
    localparam int OFFSET_WIDTH = 4;
    localparam int LINE_WIDTH = 128;

    // bus address
    localparam int ADDR_WIDTH = 32;

    // victim lfsr, galois form
    localparam int LFSR_WIDTH = 8;
    // nonzero, else the lfsr locks up
    localparam logic [LFSR_WIDTH-1:0] LFSR_SEED = 8'hA5;
    // x^8 + x^6 + x^5 + x^4 + 1, maximal length
    localparam logic [LFSR_WIDTH-1:0] LFSR_TAPS = 8'hB8;

    // one line, flat for bus transfers, per word for selection
    typedef union packed {
        logic [LINE_WIDTH-1:0] flat;
        logic [WORDS_PER_LINE-1:0][WORD_WIDTH-1:0] words;
    } cache_line_t;

endpackage

// File: source/cache_way_if.sv
`timescale 1ns/1ps

interface cache_way_if #(
    parameter int INDEX_WIDTH = 8,
    localparam int TAG_WIDTH = cache_pkg::ADDR_WIDTH - INDEX_WIDTH - cache_pkg::OFFSET_WIDTH
);

    // request side, from the datapath
    logic [INDEX_WIDTH-1:0] index;
    logic tag_we;
    logic [TAG_WIDTH-1:0] tag_wdata;
    logic dirty_wdata;
    // one enable per word bank
    logic [cache_pkg::WORDS_PER_LINE-1:0] word_we;
    logic [cache_pkg::STRB_WIDTH-1:0] byte_en;
    logic [cache_pkg::WORD_WIDTH-1:0] word_wdata;

    // read side, registered in the way
    logic [TAG_WIDTH-1:0] tag_rdata;
    logic valid_rdata;
    logic dirty_rdata;
    cache_pkg::cache_line_t line_rdata;

    modport dp (
        output index, tag_we, tag_wdata, dirty_wdata, word_we, byte_en, word_wdata,
        input tag_rdata, valid_rdata, dirty_rdata, line_rdata
    );

    modport way (
        input index, tag_we, tag_wdata, dirty_wdata, word_we, byte_en, word_wdata,
        output tag_rdata, valid_rdata, dirty_rdata, line_rdata
    );

endinterface

// File: source/cache_ctrl_if.sv
`timescale 1ns/1ps

interface cache_ctrl_if #(
    parameter int INDEX_WIDTH = 8,
    localparam int TAG_WIDTH = cache_pkg::ADDR_WIDTH - INDEX_WIDTH - cache_pkg::OFFSET_WIDTH
);

    // phase flags
    logic idle;
    logic lookup;
    logic refill;

    // buffered cpu request
    logic req_op;
    logic [TAG_WIDTH-1:0] req_tag;
    logic [INDEX_WIDTH-1:0] req_index;
    logic [cache_pkg::WORD_SEL_WIDTH-1:0] req_word;
    logic [cache_pkg::STRB_WIDTH-1:0] req_wstrb;
    logic [cache_pkg::WORD_WIDTH-1:0] req_wdata;

    // victim way and refill word counter
    logic replace_way;
    logic [cache_pkg::WORD_SEL_WIDTH-1:0] beat;

    // lookup results
    logic hit;
    logic hit_way;
    logic victim_dirty;

    modport ctrl (
        output idle, lookup, refill,
        output req_op, req_tag, req_index, req_word, req_wstrb, req_wdata,
        output replace_way, beat,
        input hit, hit_way, victim_dirty
    );

    modport dp (
        input idle, lookup, refill,
        input req_op, req_tag, req_index, req_word, req_wstrb, req_wdata,
        input replace_way, beat,
        output hit, hit_way, victim_dirty
    );

endinterface

// File: source/cache_way.sv
`timescale 1ns/1ps

module cache_way #(
    parameter int INDEX_WIDTH = 8,
    localparam int TAG_WIDTH = cache_pkg::ADDR_WIDTH - INDEX_WIDTH - cache_pkg::OFFSET_WIDTH,
    localparam int SETS = 2 ** INDEX_WIDTH
) (
    input logic clk,
    input logic rst,
    cache_way_if.way port
);

    // tag array, valid and dirty bits per set
    logic [TAG_WIDTH-1:0] tag_mem [SETS];
    logic [SETS-1:0] valid_bits;
    logic [SETS-1:0] dirty_bits;

    // four word banks, first index picks the bank
    logic [cache_pkg::WORD_WIDTH-1:0] data_mem [cache_pkg::WORDS_PER_LINE][SETS];

    // tag write and synchronous read
    always_ff @(posedge clk) begin
        if (port.tag_we) begin
            tag_mem[port.index] <= port.tag_wdata;
        end
        port.tag_rdata <= tag_mem[port.index];
    end

    // valid set by a refill tag write
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
            port.valid_rdata <= 1'b0;
        end else begin
            if (port.tag_we) begin
                valid_bits[port.index] <= 1'b1;
            end
            port.valid_rdata <= valid_bits[port.index];
        end
    end

    // refill end loads dirty_wdata, any other word write marks the line dirty
    // earlier refill beats set it too but the tag write on the last beat overrides
    always_ff @(posedge clk) begin
        if (port.tag_we) begin
            dirty_bits[port.index] <= port.dirty_wdata;
        end else if (|port.word_we) begin
            dirty_bits[port.index] <= 1'b1;
        end
        port.dirty_rdata <= dirty_bits[port.index];
    end

    // byte enabled bank writes, whole line read back
    always_ff @(posedge clk) begin
        for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
            for (int b = 0; b < cache_pkg::STRB_WIDTH; b++) begin
                if (port.word_we[w] && port.byte_en[b]) begin
                    data_mem[w][port.index][b*8 +: 8] <= port.word_wdata[b*8 +: 8];
                end
            end
            // old data on a same-cycle write
            port.line_rdata.words[w] <= data_mem[w][port.index];
        end
    end

endmodule

// File: source/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl #(
    parameter int INDEX_WIDTH = 8,
    localparam int TAG_WIDTH = cache_pkg::ADDR_WIDTH - INDEX_WIDTH - cache_pkg::OFFSET_WIDTH
) (
    input logic clk,
    input logic rst,

    // cpu request port
    input logic valid,
    input logic op,
    input logic [INDEX_WIDTH-1:0] index,
    input logic [TAG_WIDTH-1:0] tag,
    input logic [cache_pkg::OFFSET_WIDTH-1:0] offset,
    input logic [cache_pkg::STRB_WIDTH-1:0] wstrb,
    input logic [cache_pkg::WORD_WIDTH-1:0] wdata,
    output logic addr_ok,
    output logic data_ok,

    // bus handshakes
    output logic wr_req,
    input logic wr_rdy,
    output logic rd_req,
    input logic rd_rdy,
    input logic ret_valid,
    input logic ret_last,

    cache_ctrl_if.ctrl cif
);

    // one-hot phases
    localparam logic [4:0] ST_IDLE = 5'b00001;
    localparam logic [4:0] ST_LOOKUP = 5'b00010;
    localparam logic [4:0] ST_MISS = 5'b00100;
    localparam logic [4:0] ST_REPLACE = 5'b01000;
    localparam logic [4:0] ST_REFILL = 5'b10000;

    logic [4:0] state;
    logic [4:0] next_state;
    logic [cache_pkg::LFSR_WIDTH-1:0] lfsr;
    logic accept;

    assign accept = valid && addr_ok;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (accept) begin
                    next_state = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                next_state = cif.hit ? ST_IDLE : ST_MISS;
            end
            // clean victim skips the writeback
            ST_MISS: begin
                if (!cif.victim_dirty || wr_rdy) begin
                    next_state = ST_REPLACE;
                end
            end
            ST_REPLACE: begin
                if (rd_rdy) begin
                    next_state = ST_REFILL;
                end
            end
            ST_REFILL: begin
                if (ret_valid && ret_last) begin
                    next_state = ST_IDLE;
                end
            end
            default: begin
                next_state = ST_IDLE;
            end
        endcase
    end

    // request buffer
    always_ff @(posedge clk) begin
        if (accept) begin
            cif.req_op <= op;
            cif.req_tag <= tag;
            cif.req_index <= index;
            cif.req_word <= offset[cache_pkg::OFFSET_WIDTH-1 -: cache_pkg::WORD_SEL_WIDTH];
            cif.req_wstrb <= wstrb;
            cif.req_wdata <= wdata;
        end
    end

    // free running galois lfsr
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= cache_pkg::LFSR_SEED;
        end else if (lfsr[0]) begin
            lfsr <= (lfsr >> 1) ^ cache_pkg::LFSR_TAPS;
        end else begin
            lfsr <= lfsr >> 1;
        end
    end

    // victim picked once per lookup, held through the miss
    always_ff @(posedge clk) begin
        if (rst) begin
            cif.replace_way <= 1'b0;
        end else if (state == ST_LOOKUP) begin
            cif.replace_way <= lfsr[0];
        end
    end

    // refill beat counter, back to word 0 after the last beat
    always_ff @(posedge clk) begin
        if (rst) begin
            cif.beat <= '0;
        end else if (state == ST_REFILL && ret_valid) begin
            cif.beat <= ret_last ? '0 : cif.beat + 1'b1;
        end
    end

    assign cif.idle = (state == ST_IDLE);
    assign cif.lookup = (state == ST_LOOKUP);
    assign cif.refill = (state == ST_REFILL);

    // one request at a time
    assign addr_ok = (state == ST_IDLE);

    // hit in lookup, or the critical word during refill
    assign data_ok = (cif.lookup && cif.hit)
                     || (cif.refill && ret_valid && cif.beat == cif.req_word);

    // wr_req held in miss until wr_rdy, rd_req held in replace until rd_rdy
    assign wr_req = (state == ST_MISS) && cif.victim_dirty;
    assign rd_req = (state == ST_REPLACE);

endmodule

// File: source/cache_datapath.sv
`timescale 1ns/1ps

module cache_datapath #(
    parameter int INDEX_WIDTH = 8,
    localparam int TAG_WIDTH = cache_pkg::ADDR_WIDTH - INDEX_WIDTH - cache_pkg::OFFSET_WIDTH
) (
    input logic [INDEX_WIDTH-1:0] index,
    input logic ret_valid,
    input logic [cache_pkg::WORD_WIDTH-1:0] ret_data,
    output logic [cache_pkg::WORD_WIDTH-1:0] rdata,
    output logic [cache_pkg::ADDR_WIDTH-1:0] rd_addr,
    output logic [cache_pkg::ADDR_WIDTH-1:0] wr_addr,
    output logic [cache_pkg::LINE_WIDTH-1:0] wr_data,
    cache_ctrl_if.dp cif,
    cache_way_if.dp way0,
    cache_way_if.dp way1
);

    logic [INDEX_WIDTH-1:0] arr_index;
    logic hit0;
    logic hit1;
    logic write_hit;
    logic refill_beat;
    logic refill_last;
    logic [cache_pkg::WORD_WIDTH-1:0] strb_mask;
    logic [cache_pkg::WORD_WIDTH-1:0] merged_word;
    logic wr_way;
    logic [cache_pkg::WORDS_PER_LINE-1:0] word_oh;
    logic [cache_pkg::STRB_WIDTH-1:0] byte_en;
    logic [cache_pkg::WORD_WIDTH-1:0] word_wdata;
    logic [TAG_WIDTH-1:0] victim_tag;
    cache_pkg::cache_line_t victim_line;
    cache_pkg::cache_line_t hit_line;

    // cpu index while idle so the read lands for lookup
    assign arr_index = cif.idle ? index : cif.req_index;

    // tag compare in both ways
    assign hit0 = way0.valid_rdata && (way0.tag_rdata == cif.req_tag);
    assign hit1 = way1.valid_rdata && (way1.tag_rdata == cif.req_tag);
    assign cif.hit = hit0 || hit1;
    assign cif.hit_way = hit1;

    // victim state, stable through miss since the index is buffered
    assign victim_tag = cif.replace_way ? way1.tag_rdata : way0.tag_rdata;
    assign victim_line = cif.replace_way ? way1.line_rdata : way0.line_rdata;
    assign cif.victim_dirty = cif.replace_way ? (way1.valid_rdata && way1.dirty_rdata)
                                              : (way0.valid_rdata && way0.dirty_rdata);

    assign write_hit = cif.lookup && cif.hit && cif.req_op;
    assign refill_beat = cif.refill && ret_valid;
    // fourth beat is the one with ret_last
    assign refill_last = refill_beat && (cif.beat == cache_pkg::WORD_SEL_WIDTH'(3));

    // byte strobes widened to bit mask
    always_comb begin
        for (int b = 0; b < cache_pkg::STRB_WIDTH; b++) begin
            strb_mask[b*8 +: 8] = {8{cif.req_wstrb[b]}};
        end
    end

    // write miss, store data over the returned word
    assign merged_word = (ret_data & ~strb_mask) | (cif.req_wdata & strb_mask);

    // write hit goes by byte enable, refill writes whole words
    always_comb begin
        wr_way = cif.hit_way;
        word_oh = '0;
        byte_en = cif.req_wstrb;
        word_wdata = cif.req_wdata;
        if (write_hit) begin
            word_oh[cif.req_word] = 1'b1;
        end
        if (refill_beat) begin
            wr_way = cif.replace_way;
            word_oh[cif.beat] = 1'b1;
            byte_en = '1;
            if (cif.req_op && cif.beat == cif.req_word) begin
                word_wdata = merged_word;
            end else begin
                word_wdata = ret_data;
            end
        end
    end

    // way 0 request side
    assign way0.index = arr_index;
    assign way0.word_we = wr_way ? '0 : word_oh;
    assign way0.byte_en = byte_en;
    assign way0.word_wdata = word_wdata;
    assign way0.tag_we = refill_last && !cif.replace_way;
    assign way0.tag_wdata = cif.req_tag;
    // line refilled for a write is dirty at once
    assign way0.dirty_wdata = cif.req_op;

    // way 1 request side
    assign way1.index = arr_index;
    assign way1.word_we = wr_way ? word_oh : '0;
    assign way1.byte_en = byte_en;
    assign way1.word_wdata = word_wdata;
    assign way1.tag_we = refill_last && cif.replace_way;
    assign way1.tag_wdata = cif.req_tag;
    assign way1.dirty_wdata = cif.req_op;

    // line aligned bus addresses
    assign rd_addr = {cif.req_tag, cif.req_index, {cache_pkg::OFFSET_WIDTH{1'b0}}};
    assign wr_addr = {victim_tag, cif.req_index, {cache_pkg::OFFSET_WIDTH{1'b0}}};
    assign wr_data = victim_line.flat;

    // hit word, or the bus word during refill
    assign hit_line = hit1 ? way1.line_rdata : way0.line_rdata;
    assign rdata = cif.refill ? ret_data : hit_line.words[cif.req_word];

endmodule

// File: source/cache_top.sv
`timescale 1ns/1ps

module cache_top #(
    parameter int INDEX_WIDTH = 8,
    localparam int TAG_WIDTH = cache_pkg::ADDR_WIDTH - INDEX_WIDTH - cache_pkg::OFFSET_WIDTH
) (
    input logic clk,
    input logic rst,

    // cpu side
    input logic valid,
    input logic op,
    input logic [INDEX_WIDTH-1:0] index,
    input logic [TAG_WIDTH-1:0] tag,
    input logic [cache_pkg::OFFSET_WIDTH-1:0] offset,
    input logic [cache_pkg::STRB_WIDTH-1:0] wstrb,
    input logic [cache_pkg::WORD_WIDTH-1:0] wdata,
    output logic addr_ok,
    output logic data_ok,
    output logic [cache_pkg::WORD_WIDTH-1:0] rdata,

    // memory bridge side
    output logic rd_req,
    output logic [cache_pkg::ADDR_WIDTH-1:0] rd_addr,
    input logic rd_rdy,
    input logic ret_valid,
    input logic ret_last,
    input logic [cache_pkg::WORD_WIDTH-1:0] ret_data,
    output logic wr_req,
    output logic [cache_pkg::ADDR_WIDTH-1:0] wr_addr,
    output logic [cache_pkg::LINE_WIDTH-1:0] wr_data,
    input logic wr_rdy
);

    cache_ctrl_if #(.INDEX_WIDTH(INDEX_WIDTH)) ctrl_bus ();
    // one per way
    cache_way_if #(.INDEX_WIDTH(INDEX_WIDTH)) way_bus [2] ();

    cache_ctrl #(.INDEX_WIDTH(INDEX_WIDTH)) cache_ctrl_inst (
        .clk(clk), .rst(rst),
        .valid(valid), .op(op), .index(index), .tag(tag), .offset(offset),
        .wstrb(wstrb), .wdata(wdata), .addr_ok(addr_ok), .data_ok(data_ok),
        .wr_req(wr_req), .wr_rdy(wr_rdy), .rd_req(rd_req), .rd_rdy(rd_rdy),
        .ret_valid(ret_valid), .ret_last(ret_last), .cif(ctrl_bus)
    );

    cache_datapath #(.INDEX_WIDTH(INDEX_WIDTH)) cache_datapath_inst (
        .index(index), .ret_valid(ret_valid), .ret_data(ret_data), .rdata(rdata),
        .rd_addr(rd_addr), .wr_addr(wr_addr), .wr_data(wr_data),
        .cif(ctrl_bus), .way0(way_bus[0]), .way1(way_bus[1])
    );

    for (genvar i = 0; i < 2; i++) begin : g_way
        cache_way #(.INDEX_WIDTH(INDEX_WIDTH)) cache_way_inst (
            .clk(clk),
            .rst(rst),
            .port(way_bus[i])
        );
    end

endmodule

// File: testbench/tb_cache_top.sv
`timescale 1ns/1ps

module tb_cache_top;

    localparam int INDEX_WIDTH = 8;
    localparam int TAG_WIDTH = cache_pkg::ADDR_WIDTH - INDEX_WIDTH - cache_pkg::OFFSET_WIDTH;
    localparam int CLK_PERIOD = 20;
    localparam int NUM_REQUESTS = 600;
    localparam int CYCLES_PER_REQUEST = 60;

    // dut ports
    logic clk, rst;
    logic valid, op, addr_ok, data_ok;
    logic [INDEX_WIDTH-1:0] index;
    logic [TAG_WIDTH-1:0] tag;
    logic [3:0] offset, wstrb;
    logic [31:0] wdata, rdata, rd_addr, wr_addr, ret_data;
    logic rd_req, rd_rdy, ret_valid, ret_last, wr_req, wr_rdy;
    logic [127:0] wr_data;

    // few tags and sets so lines conflict
    logic [TAG_WIDTH-1:0] tag_pool [4] = '{20'h00012, 20'h0a5c3, 20'h7f001, 20'hc0de5};
    logic [INDEX_WIDTH-1:0] index_pool [2] = '{8'h03, 8'h9c};

    // architectural and bridge memories keyed by byte address
    logic [31:0] arch_mem [bit [31:0]];
    logic [31:0] bus_mem [bit [31:0]];
    // lines known to be resident and lines written since their refill
    bit resident [bit [31:0]];
    bit line_dirty [bit [31:0]];

    integer seed = 32'h67ab;
    bit started = 0;
    // request in flight as seen by the bridge
    logic [TAG_WIDTH-1:0] cur_tag;
    logic [INDEX_WIDTH-1:0] cur_index;
    logic [1:0] cur_word;
    logic cur_op;
    bit refill_active = 0;
    bit wb_seen = 0;
    int beat_num = 0;

    cache_top #(.INDEX_WIDTH(INDEX_WIDTH)) cache_top_inst (.*);

    function automatic logic [31:0] line_addr(logic [TAG_WIDTH-1:0] t, logic [INDEX_WIDTH-1:0] i);
        return {t, i, 4'h0};
    endfunction

    // every address bit feeds the pattern
    function automatic logic [31:0] fill_word(logic [31:0] a);
        return {a[15:0], a[31:16]} ^ (a * 32'h9e37_79b9);
    endfunction

    function automatic int rand_below(int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [31:0] nw,
                                                logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = nw[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // word 0 in the low bits
    function automatic logic [127:0] arch_line(logic [31:0] a);
        return {arch_mem[a + 12], arch_mem[a + 8], arch_mem[a + 4], arch_mem[a]};
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("Mismatch %s: expected %0h, actual %0h",
                                     name, expected, actual));
        end
    endtask

    // bridge side of a dirty victim writeback
    task automatic serve_writeback();
        logic [31:0] a;
        repeat (rand_below(4)) @(negedge clk);
        wr_rdy = 1'b1;
        @(posedge clk);
        a = wr_addr;
        check_value("writeback request held", 1, wr_req);
        check_value("writeback offset", 0, a[3:0]);
        check_value("writeback index", cur_index, a[4 +: INDEX_WIDTH]);
        check_value("writeback of a written line", 1, line_dirty[a]);
        check_value("writeback data", arch_line(a), wr_data);
        for (int w = 0; w < 4; w++) begin
            bus_mem[a + 4*w] = wr_data[32*w +: 32];
        end
        line_dirty[a] = 1'b0;
        resident[a] = 1'b0;
        wb_seen = 1'b1;
        @(negedge clk);
        wr_rdy = 1'b0;
    endtask

    // address handshake then four beats with random gaps
    task automatic serve_refill();
        logic [31:0] a;
        repeat (rand_below(4)) @(negedge clk);
        rd_rdy = 1'b1;
        @(posedge clk);
        a = rd_addr;
        check_value("refill request held", 1, rd_req);
        check_value("refill address", line_addr(cur_tag, cur_index), a);
        // clean eviction is invisible so the whole set is forgotten
        if (!wb_seen) begin
            for (int t = 0; t < 4; t++) begin
                resident[line_addr(tag_pool[t], cur_index)] = 1'b0;
            end
        end
        wb_seen = 1'b0;
        resident[a] = 1'b1;
        line_dirty[a] = cur_op;
        @(negedge clk);
        rd_rdy = 1'b0;
        refill_active = 1'b1;
        for (int b = 0; b < 4; b++) begin
            repeat (rand_below(3)) @(negedge clk);
            beat_num = b;
            ret_valid = 1'b1;
            ret_last = (b == 3);
            ret_data = bus_mem[a + 4*b];
            @(negedge clk);
            ret_valid = 1'b0;
            ret_last = 1'b0;
        end
        refill_active = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : watchdog
        #(NUM_REQUESTS * CYCLES_PER_REQUEST * CLK_PERIOD);
        report_failure("timeout: the cache did not finish all requests in time");
    end

    // memory bridge
    initial begin : bridge
        wait (started);
        forever begin
            @(negedge clk);
            if (wr_req) begin
                serve_writeback();
            end else if (rd_req) begin
                serve_refill();
            end
        end
    end

    // one data_ok per accepted request
    initial begin : reply_monitor
        int open_reqs;
        open_reqs = 0;
        wait (started);
        forever begin
            @(posedge clk);
            if (data_ok) begin
                check_value("replies per request", 1, open_reqs);
                open_reqs--;
            end
            if (valid && addr_ok) begin
                check_value("requests before reply", 0, open_reqs);
                open_reqs++;
            end
        end
    end

    initial begin : stimulus
        logic [31:0] line;
        logic [31:0] word_a;
        logic [31:0] exp_rdata;
        bit expect_hit;
        bit saw_bus;
        int cycles;
        rst = 1'b1;
        {valid, op, index, tag, offset, wstrb, wdata} = '0;
        {rd_rdy, wr_rdy, ret_valid, ret_last, ret_data} = '0;
        for (int t = 0; t < 4; t++) begin
            for (int i = 0; i < 2; i++) begin
                line = line_addr(tag_pool[t], index_pool[i]);
                resident[line] = 1'b0;
                line_dirty[line] = 1'b0;
                for (int w = 0; w < 4; w++) begin
                    arch_mem[line + 4*w] = fill_word(line + 4*w);
                    bus_mem[line + 4*w] = fill_word(line + 4*w);
                end
            end
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        check_value("reset addr_ok", 1, addr_ok);
        check_value("reset data_ok", 0, data_ok);
        check_value("reset rd_req", 0, rd_req);
        check_value("reset wr_req", 0, wr_req);
        started = 1'b1;
        for (int n = 0; n < NUM_REQUESTS; n++) begin
            @(negedge clk);
            valid = 1'b1;
            op = rand_below(2);
            tag = tag_pool[rand_below(4)];
            index = index_pool[rand_below(2)];
            offset = 4'(rand_below(4) << 2);
            wstrb = 4'(rand_below(16));
            wdata = $random(seed);
            // held until addr_ok
            do begin
                @(posedge clk);
            end while (!addr_ok);
            cur_tag = tag;
            cur_index = index;
            cur_word = offset[3:2];
            cur_op = op;
            line = line_addr(tag, index);
            word_a = line + {cur_word, 2'b00};
            expect_hit = resident[line];
            if (op) begin
                arch_mem[word_a] = merge_bytes(arch_mem[word_a], wdata, wstrb);
                line_dirty[line] = 1'b1;
            end
            exp_rdata = arch_mem[word_a];
            @(negedge clk);
            valid = 1'b0;
            cycles = 0;
            saw_bus = 1'b0;
            while (!data_ok || cycles == 0) begin
                @(posedge clk);
                cycles++;
                saw_bus = saw_bus | rd_req | wr_req;
            end
            if (!cur_op) begin
                check_value("read data", exp_rdata, rdata);
            end
            if (expect_hit) begin
                check_value("hit latency", 1, cycles);
                check_value("hit without bus request", 0, saw_bus);
            end
            if (cycles == 1) begin
                resident[line] = 1'b1;
            end else begin
                // miss reply rides on the critical word
                check_value("reply on refill beat", 1, refill_active && ret_valid);
                check_value("critical word beat", cur_word, beat_num);
            end
        end
        while (!addr_ok) begin
            @(posedge clk);
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: sim.f
source/cache_pkg.sv
source/cache_way_if.sv
source/cache_ctrl_if.sv
source/cache_way.sv
source/cache_ctrl.sv
source/cache_datapath.sv
source/cache_top.sv
testbench/tb_cache_top.sv
